//--- Bender.yml
package:
  name: bpu

sources:
  - source/rv_isa_pkg.sv
  - source/bp_geometry_pkg.sv
  - source/inst_classify.sv
  - source/tage_predictor.sv
  - source/btb.sv
  - source/return_stack.sv
  - source/bpu_top.sv
  - target: simulation
    files:
      - sim/tb_bpu.sv

//--- list.f
source/rv_isa_pkg.sv
source/bp_geometry_pkg.sv
source/inst_classify.sv
source/tage_predictor.sv
source/btb.sv
source/return_stack.sv
source/bpu_top.sv
sim/tb_bpu.sv

//--- sim/tb_bpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bpu;

    localparam int n_plain   = 40;
    localparam int n_jal     = 6;
    localparam int n_branch  = 300;
    localparam int n_callret = 120;
    localparam int n_jalr    = 4;
    // at most four cycles per step plus the drain and overflow phases
    localparam int max_cycles = 8 + 100 + 4 * (n_plain + 2 * n_jal + n_branch + n_callret
                                + 3 * bp_geometry_pkg::ras_depth + 2 * n_jalr);

    logic clk;
    logic rst;
    logic [31:0] if_pc;
    logic [31:0] if_inst;
    logic [31:0] ex_inst;
    bp_geometry_pkg::ex_feedback_t ex;
    logic is_cti;
    logic pred_taken;
    logic [31:0] pred_pc;
    logic [15:0] history;

    // reference model state
    bp_geometry_pkg::ctr_t m_bim [512];
    logic [9:0] m_tag [2][256];
    bp_geometry_pkg::ctr_t m_ctr [2][256];
    logic [15:0] m_hist;
    logic m_bvalid [256];
    logic [13:0] m_btag [256];
    logic [31:0] m_btgt [256];
    logic [31:0] m_ras [32];
    int m_depth;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    bpu_top i_bpu_top (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst), .ex_inst_i(ex_inst),
        .ex_i(ex), .is_cti_o(is_cti), .pred_taken_o(pred_taken), .pred_pc_o(pred_pc),
        .history_o(history)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic [7:0] t_idx(input int t, input logic [31:0] pc,
                                         input logic [15:0] h);
        return (t == 0) ? (pc[7:0] ^ h[7:0]) : (pc[7:0] ^ h[15:8]);
    endfunction

    function automatic logic [9:0] t_tag(input int t, input logic [31:0] pc,
                                         input logic [15:0] h);
        return (t == 0) ? (pc[17:8] ^ h[15:6]) : (pc[17:8] ^ {2'b00, h[7:0]});
    endfunction

    // -1 means bimodal, else the longest tagged table that matches
    function automatic int provider(input logic [31:0] pc, input logic [15:0] h);
        for (int t = 1; t >= 0; t--)
            if (m_tag[t][t_idx(t, pc, h)] == t_tag(t, pc, h))
                return t;
        return -1;
    endfunction

    function automatic logic dir_pred(input logic [31:0] pc, input logic [15:0] h);
        int p;
        p = provider(pc, h);
        if (p < 0)
            return m_bim[pc[9:1]][1];
        return m_ctr[p][t_idx(p, pc, h)][1];
    endfunction

    function automatic bp_geometry_pkg::ctr_t sat(input bp_geometry_pkg::ctr_t c, input logic up);
        if (up)
            return (c == 2'd3) ? 2'd3 : c + 2'd1;
        return (c == 2'd0) ? 2'd0 : c - 2'd1;
    endfunction

    function automatic logic btb_hit(input logic [31:0] pc);
        return m_bvalid[pc[9:2]] && (m_btag[pc[9:2]] == pc[31:18]);
    endfunction

    task automatic expect_pred(input rv_isa_pkg::cti_class_e cls, input logic [31:0] pc,
                               input logic [31:0] off, output logic tk, output logic [31:0] npc);
        logic hit;
        hit = btb_hit(pc);
        tk  = 1'b0;
        npc = pc + 32'd4;
        case (cls)
            rv_isa_pkg::cti_ret: begin
                if (m_depth > 0) begin
                    tk  = 1'b1;
                    npc = m_ras[m_depth - 1];
                end else if (hit) begin
                    tk  = 1'b1;
                    npc = m_btgt[pc[9:2]];
                end
            end
            rv_isa_pkg::cti_jalr, rv_isa_pkg::cti_call_jalr: begin
                if (hit) begin
                    tk  = 1'b1;
                    npc = m_btgt[pc[9:2]];
                end
            end
            rv_isa_pkg::cti_jal: begin
                tk  = 1'b1;
                npc = hit ? m_btgt[pc[9:2]] : pc + off;
            end
            rv_isa_pkg::cti_cond_branch: begin
                tk = dir_pred(pc, m_hist);
                if (tk)
                    npc = hit ? m_btgt[pc[9:2]] : pc + off;
            end
            default: tk = 1'b0;
        endcase
    endtask

    task automatic model_update(input bp_geometry_pkg::ex_feedback_t f);
        int p;
        int a;
        logic [8:0] bi;
        if (f.cls == rv_isa_pkg::cti_cond_branch) begin
            p  = provider(f.pc, f.history);   // provider from the fetch time history
            bi = f.pc[9:1];
            m_bim[bi] = sat(m_bim[bi], f.taken);
            if (p >= 0)
                m_ctr[p][t_idx(p, f.pc, f.history)] =
                    sat(m_ctr[p][t_idx(p, f.pc, f.history)], f.taken);
            if (f.mispredict && p < 1) begin
                a = p + 1;
                m_tag[a][t_idx(a, f.pc, f.history)] = t_tag(a, f.pc, f.history);
                m_ctr[a][t_idx(a, f.pc, f.history)] = f.taken ? 2'd2 : 2'd1;
            end
            m_hist = {m_hist[14:0], f.taken};
        end
        if (f.taken && f.cls != rv_isa_pkg::cti_none) begin
            m_bvalid[f.pc[9:2]] = 1'b1;
            m_btag[f.pc[9:2]]   = f.pc[31:18];
            m_btgt[f.pc[9:2]]   = f.target;
        end
        if (f.cls == rv_isa_pkg::cti_jal || f.cls == rv_isa_pkg::cti_call_jalr) begin
            if (m_depth == 32) begin
                m_ras[0] = f.pc + 32'd4;    // full stack restarts at entry 0
                m_depth  = 1;
            end else begin
                m_ras[m_depth] = f.pc + 32'd4;
                m_depth++;
            end
        end else if (f.cls == rv_isa_pkg::cti_ret && m_depth > 0) begin
            m_depth--;
        end
    endtask

    // lookup driven on the rising edge and outputs sampled at the falling edge
    task automatic fetch(input string name, input logic [31:0] pc, input logic [31:0] inst,
                         input rv_isa_pkg::cti_class_e cls, input logic [31:0] off,
                         output logic tk);
        logic [31:0] npc;
        @(posedge clk);
        if_pc   <= pc;
        if_inst <= inst;
        @(negedge clk);
        expect_pred(cls, pc, off, tk, npc);
        compare({name, " cti"}, cls != rv_isa_pkg::cti_none, is_cti);
        compare({name, " taken"}, tk, pred_taken);
        compare({name, " next pc"}, npc, pred_pc);
        compare({name, " history"}, m_hist, history);
    endtask

    task automatic resolve(input logic [31:0] pc, input logic [31:0] inst,
                           input rv_isa_pkg::cti_class_e cls, input logic tk,
                           input logic mis, input logic [31:0] tgt);
        bp_geometry_pkg::ex_feedback_t f;
        f.valid      = 1'b1;
        f.taken      = tk;
        f.mispredict = mis;
        f.pc         = pc;
        f.target     = tgt;
        f.history    = history;   // as seen at this branch's fetch
        f.cls        = cls;
        @(posedge clk);
        ex      <= f;
        ex_inst <= inst;
        @(posedge clk);
        ex.valid <= 1'b0;
        model_update(f);
    endtask

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd6, 5'd5, 3'b001, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h000, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    initial begin
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] off;
        logic [31:0] tgt;
        logic [20:0] jimm;
        logic [12:0] bimm;
        logic [31:0] br_pc [4];
        logic [31:0] ret_pc [2];
        logic tk;
        logic pt;
        void'($urandom(32'hde06));
        rst     = 1'b1;
        if_pc   = '0;
        if_inst = '0;
        ex_inst = '0;
        ex      = '0;
        for (int i = 0; i < 512; i++)
            m_bim[i] = 2'd1;
        for (int i = 0; i < 256; i++) begin
            m_tag[0][i] = '0;
            m_tag[1][i] = '0;
            m_ctr[0][i] = 2'd1;
            m_ctr[1][i] = 2'd1;
            m_bvalid[i] = 1'b0;
        end
        m_hist  = '0;
        m_depth = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // plain instructions fall through
        for (int i = 0; i < n_plain; i++) begin
            pc        = $urandom() & 32'hffff_fffc;
            inst      = $urandom();
            inst[6:0] = (i % 2) ? 7'b0010011 : 7'b0110011;
            fetch("plain", pc, inst, rv_isa_pkg::cti_none, 32'd0, pt);
        end

        for (int i = 0; i < n_jal; i++) begin
            pc   = $urandom() & 32'hffff_fffc;
            jimm = 21'($urandom() << 1);
            off  = {{11{jimm[20]}}, jimm};
            inst = enc_jal(5'd1, jimm);
            fetch("jal cold", pc, inst, rv_isa_pkg::cti_jal, off, pt);
            tgt = $urandom() & 32'hffff_fffc;
            resolve(pc, inst, rv_isa_pkg::cti_jal, 1'b1, 1'b1, tgt);
            fetch("jal trained", pc, inst, rv_isa_pkg::cti_jal, off, pt);
            compare("jal btb target", tgt, pred_pc);
        end

        // four branch sites with always, never, alternating and random outcomes
        for (int i = 0; i < 4; i++)
            br_pc[i] = $urandom() & 32'hffff_fffc;
        bimm = 13'($urandom() << 1);
        off  = {{19{bimm[12]}}, bimm};
        inst = enc_branch(bimm);
        for (int i = 0; i < n_branch; i++) begin
            int k;
            k  = $urandom_range(3);
            pc = br_pc[k];
            case (k)
                0: tk = 1'b1;
                1: tk = 1'b0;
                2: tk = i[1];
                default: tk = $urandom_range(1);
            endcase
            fetch("branch", pc, inst, rv_isa_pkg::cti_cond_branch, off, pt);
            resolve(pc, inst, rv_isa_pkg::cti_cond_branch, tk, pt != tk, pc + off);
        end
        fetch("branch last", br_pc[0], inst, rv_isa_pkg::cti_cond_branch, off, pt);

        // leading rets empty the stack left by the jal phase
        ret_pc[0] = $urandom() & 32'hffff_fffc;
        ret_pc[1] = $urandom() & 32'hffff_fffc;
        for (int i = 0; i < n_callret; i++) begin
            if (i < 8 || $urandom_range(1) == 0) begin
                pc   = ret_pc[$urandom_range(1)];
                inst = enc_jalr(5'd0, 5'd1);
                fetch("ret", pc, inst, rv_isa_pkg::cti_ret, 32'd0, pt);
                tgt = (m_depth > 0) ? m_ras[m_depth - 1] : ($urandom() & 32'hffff_fffc);
                resolve(pc, inst, rv_isa_pkg::cti_ret, 1'b1, 1'b0, tgt);
            end else if ($urandom_range(1)) begin
                pc   = $urandom() & 32'hffff_fffc;
                jimm = 21'($urandom() << 1);
                off  = {{11{jimm[20]}}, jimm};
                inst = enc_jal(5'd1, jimm);
                fetch("call jal", pc, inst, rv_isa_pkg::cti_jal, off, pt);
                resolve(pc, inst, rv_isa_pkg::cti_jal, 1'b1, 1'b0, pc + off);
            end else begin
                pc   = $urandom() & 32'hffff_fffc;
                inst = enc_jalr(5'd1, 5'd5);
                fetch("call jalr", pc, inst, rv_isa_pkg::cti_call_jalr, 32'd0, pt);
                tgt = $urandom() & 32'hffff_fffc;
                resolve(pc, inst, rv_isa_pkg::cti_call_jalr, 1'b1, 1'b0, tgt);
            end
        end

        inst = enc_jalr(5'd0, 5'd1);
        while (m_depth > 0)
            resolve(ret_pc[0], inst, rv_isa_pkg::cti_ret, 1'b1, 1'b0, ret_pc[1]);
        for (int i = 0; i <= bp_geometry_pkg::ras_depth; i++) begin
            pc = $urandom() & 32'hffff_fffc;
            resolve(pc, enc_jal(5'd1, 21'd8), rv_isa_pkg::cti_jal, 1'b1, 1'b0, pc + 32'd8);
        end
        fetch("ret after overflow", ret_pc[0], inst, rv_isa_pkg::cti_ret, 32'd0, pt);
        compare("ras overflow top", pc + 32'd4, pred_pc);
        resolve(ret_pc[0], inst, rv_isa_pkg::cti_ret, 1'b1, 1'b0, pc + 32'd4);
        pc = $urandom() & 32'hffff_fffc;
        fetch("ret after pop", pc, inst, rv_isa_pkg::cti_ret, 32'd0, pt);

        for (int i = 0; i < n_jalr; i++) begin
            pc   = $urandom() & 32'hffff_fffc;
            inst = enc_jalr(5'd0, 5'd5);
            fetch("jalr cold", pc, inst, rv_isa_pkg::cti_jalr, 32'd0, pt);
            tgt = $urandom() & 32'hffff_fffc;
            resolve(pc, inst, rv_isa_pkg::cti_jalr, 1'b1, 1'b1, tgt);
            fetch("jalr trained", pc, inst, rv_isa_pkg::cti_jalr, 32'd0, pt);
            compare("jalr btb target", tgt, pred_pc);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/bp_geometry_pkg.sv
`default_nettype none

package bp_geometry_pkg;

    localparam int xlen        = 32;
    localparam int ghist_w     = 16;
    localparam int bim_entries = 512;
    localparam int bim_idx_w   = 9;
    localparam int tag_entries = 256; // per tagged table
    localparam int tag_idx_w   = 8;
    localparam int tag_w       = 10;
    localparam int btb_entries = 256;
    localparam int btb_idx_w   = 8;
    localparam int btb_tag_w   = 14;
    localparam int ras_depth   = 32;
    localparam int ras_idx_w   = $clog2(ras_depth);
    localparam int ras_ptr_w   = ras_idx_w + 1; // holds 0..ras_depth

    // 2-bit saturating counter whose msb is the taken prediction
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_weak_nt = 2'd1;
    localparam ctr_t ctr_weak_t  = 2'd2;

    typedef enum logic [1:0] {
        prov_bim,
        prov_t0,
        prov_t1
    } provider_e;

    // hashed position of one pc/history pair in a tagged table
    typedef struct packed {
        logic [tag_idx_w-1:0] idx;
        logic [tag_w-1:0]     tag;
    } tag_lookup_t;

    typedef struct packed {
        logic [btb_tag_w-1:0] tag;
        logic [xlen-1:0]      target;
    } btb_entry_t;

    // one resolved control transfer from execute
    typedef struct packed {
        logic                   valid;
        logic                   taken;
        logic                   mispredict;
        logic [xlen-1:0]        pc;
        logic [xlen-1:0]        target;
        logic [ghist_w-1:0]     history;    // history seen at fetch
        rv_isa_pkg::cti_class_e cls;
    } ex_feedback_t;

    function automatic ctr_t ctr_next(input ctr_t c, input logic taken);
        if (taken)
            return (c == 2'd3) ? c : c + 2'd1;
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

endpackage

`default_nettype wire

//--- source/bpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_top (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire [bp_geometry_pkg::xlen-1:0]     if_pc_i,
    input  wire [bp_geometry_pkg::xlen-1:0]     if_inst_i,
    input  wire [bp_geometry_pkg::xlen-1:0]     ex_inst_i,
    input  wire bp_geometry_pkg::ex_feedback_t  ex_i,
    output logic                                is_cti_o,
    output logic                                pred_taken_o,
    output logic [bp_geometry_pkg::xlen-1:0]    pred_pc_o,
    output logic [bp_geometry_pkg::ghist_w-1:0] history_o
);

    rv_isa_pkg::cti_class_e if_cls;
    rv_isa_pkg::cti_class_e ex_cls;
    logic [bp_geometry_pkg::xlen-1:0] if_off;
    bp_geometry_pkg::ex_feedback_t ex_fb;
    logic tage_taken;
    logic btb_hit;
    logic [bp_geometry_pkg::xlen-1:0] btb_target;
    logic ras_empty;
    logic [bp_geometry_pkg::xlen-1:0] ras_top;
    logic [bp_geometry_pkg::xlen-1:0] pc_plus4;
    logic [bp_geometry_pkg::xlen-1:0] direct_pc;   // pc relative target
    logic [bp_geometry_pkg::xlen-1:0] static_pc;

    inst_classify i_if_classify (.inst_i(if_inst_i), .class_o(if_cls), .offset_o(if_off));
    inst_classify i_ex_classify (.inst_i(ex_inst_i), .class_o(ex_cls), .offset_o());

    // class comes from our own decode of the execute instruction
    always_comb begin
        ex_fb     = ex_i;
        ex_fb.cls = ex_cls;
    end

    tage_predictor i_tage (.clk(clk), .rst(rst), .pc_i(if_pc_i), .pred_taken_o(tage_taken),
                           .ex_i(ex_fb), .history_o(history_o));

    btb i_btb (.clk(clk), .rst(rst), .pc_i(if_pc_i), .hit_o(btb_hit), .target_o(btb_target),
               .ex_i(ex_fb));

    return_stack i_ras (.clk(clk), .rst(rst), .ex_i(ex_fb), .empty_o(ras_empty),
                        .top_o(ras_top));

    assign pc_plus4  = if_pc_i + bp_geometry_pkg::xlen'(4);
    assign direct_pc = if_pc_i + if_off;
    assign static_pc = btb_hit ? btb_target : direct_pc;  // btb wins when present
    assign is_cti_o  = (if_cls != rv_isa_pkg::cti_none);

    always_comb begin
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;
        case (if_cls)
            rv_isa_pkg::cti_ret: begin
                if (!ras_empty || btb_hit) begin
                    pred_taken_o = 1'b1;
                    pred_pc_o    = !ras_empty ? ras_top : btb_target;
                end
            end
            rv_isa_pkg::cti_jalr, rv_isa_pkg::cti_call_jalr: begin
                if (btb_hit) begin
                    pred_taken_o = 1'b1;
                    pred_pc_o    = btb_target;
                end
            end
            rv_isa_pkg::cti_jal: begin
                pred_taken_o = 1'b1;
                pred_pc_o    = static_pc;
            end
            rv_isa_pkg::cti_cond_branch: begin
                pred_taken_o = tage_taken;
                if (tage_taken)
                    pred_pc_o = static_pc;
            end
            default: begin
                pred_taken_o = 1'b0;   // sequential fetch
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  wire                                clk,
    input  wire                                rst,
    input  wire [bp_geometry_pkg::xlen-1:0]    pc_i,
    output logic                               hit_o,
    output logic [bp_geometry_pkg::xlen-1:0]   target_o,
    input  wire bp_geometry_pkg::ex_feedback_t ex_i
);

    bp_geometry_pkg::btb_entry_t ent_q [bp_geometry_pkg::btb_entries];
    logic [bp_geometry_pkg::btb_entries-1:0] valid_q;

    logic [bp_geometry_pkg::btb_idx_w-1:0] lk_idx;
    logic [bp_geometry_pkg::btb_idx_w-1:0] wr_idx;
    logic [bp_geometry_pkg::btb_tag_w-1:0] lk_tag;
    logic [bp_geometry_pkg::btb_tag_w-1:0] wr_tag;
    logic wr_en;

    // word index and a tag from the top pc bits
    assign lk_idx = pc_i[bp_geometry_pkg::btb_idx_w+1:2];
    assign lk_tag = pc_i[bp_geometry_pkg::xlen-1 -: bp_geometry_pkg::btb_tag_w];
    assign wr_idx = ex_i.pc[bp_geometry_pkg::btb_idx_w+1:2];
    assign wr_tag = ex_i.pc[bp_geometry_pkg::xlen-1 -: bp_geometry_pkg::btb_tag_w];

    assign hit_o    = valid_q[lk_idx] && (ent_q[lk_idx].tag == lk_tag);
    assign target_o = ent_q[lk_idx].target;

    // any taken control transfer trains the buffer
    assign wr_en = ex_i.valid && ex_i.taken && (ex_i.cls != rv_isa_pkg::cti_none);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ent_q[wr_idx].tag    <= wr_tag;
            ent_q[wr_idx].target <= ex_i.target;
        end
    end

    // a trained entry is visible to the very next lookup
    a_write_hits: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> (pc_i != $past(ex_i.pc)) || (hit_o && target_o == $past(ex_i.target)));

endmodule

`default_nettype wire

//--- source/inst_classify.sv
`timescale 1ns/1ps
`default_nettype none

module inst_classify (
    input  wire [bp_geometry_pkg::xlen-1:0]  inst_i,
    output rv_isa_pkg::cti_class_e           class_o,
    output logic [bp_geometry_pkg::xlen-1:0] offset_o
);

    rv_isa_pkg::opcode_e opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [bp_geometry_pkg::xlen-1:0] b_imm;
    logic [bp_geometry_pkg::xlen-1:0] j_imm;

    assign opcode = rv_isa_pkg::opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    // b-type with bit 0 implied zero
    assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // j-type
    assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        class_o  = rv_isa_pkg::cti_none;
        offset_o = '0;
        case (opcode)
            rv_isa_pkg::op_branch: begin
                class_o  = rv_isa_pkg::cti_cond_branch;
                offset_o = b_imm;
            end
            rv_isa_pkg::op_jal: begin
                class_o  = rv_isa_pkg::cti_jal;
                offset_o = j_imm;
            end
            rv_isa_pkg::op_jalr: begin
                // register based target with no static offset
                if (rd == rv_isa_pkg::reg_zero && rs1 == rv_isa_pkg::reg_ra)
                    class_o = rv_isa_pkg::cti_ret;
                else if (rd != rv_isa_pkg::reg_zero)
                    class_o = rv_isa_pkg::cti_call_jalr;
                else
                    class_o = rv_isa_pkg::cti_jalr;   // plain indirect jump
            end
            default: begin
                class_o = rv_isa_pkg::cti_none;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/return_stack.sv
`timescale 1ns/1ps
`default_nettype none

module return_stack (
    input  wire                                clk,
    input  wire                                rst,
    input  wire bp_geometry_pkg::ex_feedback_t ex_i,
    output logic                               empty_o,
    output logic [bp_geometry_pkg::xlen-1:0]   top_o
);

    logic [bp_geometry_pkg::xlen-1:0]      stack_q [bp_geometry_pkg::ras_depth];
    logic [bp_geometry_pkg::ras_ptr_w-1:0] ptr_q;   // current depth
    logic [bp_geometry_pkg::ras_idx_w-1:0] wr_idx;
    logic [bp_geometry_pkg::ras_idx_w-1:0] top_idx;
    logic push;
    logic pop;
    logic full;

    assign push = ex_i.valid && (ex_i.cls == rv_isa_pkg::cti_jal ||
                                 ex_i.cls == rv_isa_pkg::cti_call_jalr);
    assign pop  = ex_i.valid && (ex_i.cls == rv_isa_pkg::cti_ret) && !empty_o;

    assign full    = (ptr_q == bp_geometry_pkg::ras_ptr_w'(bp_geometry_pkg::ras_depth));
    assign empty_o = (ptr_q == '0);

    // low bits wrap to entry 0 when full
    assign wr_idx  = ptr_q[bp_geometry_pkg::ras_idx_w-1:0];
    assign top_idx = wr_idx - bp_geometry_pkg::ras_idx_w'(1);
    assign top_o   = stack_q[top_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (push) begin
            ptr_q <= full ? bp_geometry_pkg::ras_ptr_w'(1) : ptr_q + 1'b1;
        end else if (pop) begin
            ptr_q <= ptr_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            stack_q[wr_idx] <= ex_i.pc + bp_geometry_pkg::xlen'(4); // return address
    end

    a_depth_bound: assert property (@(posedge clk) disable iff (rst)
        ptr_q <= bp_geometry_pkg::ras_depth);

endmodule

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // major opcodes of the rv32i control transfers
    typedef enum logic [6:0] {
        op_other  = 7'b0000000,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    // control-transfer class as seen by the predictor
    typedef enum logic [2:0] {
        cti_none,
        cti_cond_branch,
        cti_jal,          // jal always links, so it counts as a call
        cti_call_jalr,
        cti_ret,
        cti_jalr
    } cti_class_e;

    localparam logic [4:0] reg_zero = 5'd0;
    localparam logic [4:0] reg_ra   = 5'd1; // link register, marks a return

endpackage

`default_nettype wire

//--- source/tage_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module tage_predictor (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire [bp_geometry_pkg::xlen-1:0]         pc_i,
    output logic                                    pred_taken_o,
    input  wire bp_geometry_pkg::ex_feedback_t      ex_i,
    output logic [bp_geometry_pkg::ghist_w-1:0]     history_o
);

    bp_geometry_pkg::ctr_t bim_q [bp_geometry_pkg::bim_entries];
    logic [bp_geometry_pkg::tag_w-1:0] tag_q [2][bp_geometry_pkg::tag_entries];
    bp_geometry_pkg::ctr_t tctr_q [2][bp_geometry_pkg::tag_entries];
    logic [bp_geometry_pkg::ghist_w-1:0] ghist_q;

    bp_geometry_pkg::tag_lookup_t lk [2];   // fetch side
    bp_geometry_pkg::tag_lookup_t up [2];   // feedback side
    logic [1:0] lk_hit;
    logic [1:0] up_hit;
    bp_geometry_pkg::provider_e lk_prov;
    bp_geometry_pkg::provider_e up_prov;
    logic [bp_geometry_pkg::bim_idx_w-1:0] lk_bim_idx;
    logic [bp_geometry_pkg::bim_idx_w-1:0] up_bim_idx;
    logic upd;
    logic up_tbl;     // tagged table of the provider
    logic alloc_tbl;  // next longer table after the provider

    // t0 folds the upper history into its tag, t1 into its index
    function automatic bp_geometry_pkg::tag_lookup_t hash(
        input logic                                tbl,
        input logic [bp_geometry_pkg::xlen-1:0]    pc,
        input logic [bp_geometry_pkg::ghist_w-1:0] h
    );
        bp_geometry_pkg::tag_lookup_t r;
        if (!tbl) begin
            r.idx = pc[7:0] ^ h[7:0];
            r.tag = pc[17:8] ^ h[15:6];
        end else begin
            r.idx = pc[7:0] ^ h[15:8];
            r.tag = pc[17:8] ^ bp_geometry_pkg::tag_w'(h[7:0]);
        end
        return r;
    endfunction

    function automatic bp_geometry_pkg::provider_e pick(input logic [1:0] hit);
        if (hit[1])
            return bp_geometry_pkg::prov_t1;
        if (hit[0])
            return bp_geometry_pkg::prov_t0;
        return bp_geometry_pkg::prov_bim;
    endfunction

    always_comb begin
        for (int t = 0; t < 2; t++) begin
            lk[t]     = hash(t[0], pc_i, ghist_q);
            up[t]     = hash(t[0], ex_i.pc, ex_i.history);
            lk_hit[t] = (tag_q[t][lk[t].idx] == lk[t].tag);
            up_hit[t] = (tag_q[t][up[t].idx] == up[t].tag);
        end
    end

    assign lk_bim_idx = pc_i[bp_geometry_pkg::bim_idx_w:1];
    assign up_bim_idx = ex_i.pc[bp_geometry_pkg::bim_idx_w:1];
    assign lk_prov    = pick(lk_hit);
    assign up_prov    = pick(up_hit);   // provider as it stood at fetch

    always_comb begin
        case (lk_prov)
            bp_geometry_pkg::prov_t1: pred_taken_o = tctr_q[1][lk[1].idx][1];
            bp_geometry_pkg::prov_t0: pred_taken_o = tctr_q[0][lk[0].idx][1];
            default:                  pred_taken_o = bim_q[lk_bim_idx][1];
        endcase
    end

    assign upd       = ex_i.valid && (ex_i.cls == rv_isa_pkg::cti_cond_branch);
    assign up_tbl    = (up_prov == bp_geometry_pkg::prov_t1);
    assign alloc_tbl = (up_prov == bp_geometry_pkg::prov_t0);
    assign history_o = ghist_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
            for (int i = 0; i < bp_geometry_pkg::bim_entries; i++)
                bim_q[i] <= bp_geometry_pkg::ctr_weak_nt;
            for (int t = 0; t < 2; t++) begin
                for (int i = 0; i < bp_geometry_pkg::tag_entries; i++) begin
                    tag_q[t][i]  <= '0;
                    tctr_q[t][i] <= bp_geometry_pkg::ctr_weak_nt;
                end
            end
        end else if (upd) begin
            ghist_q           <= {ghist_q[bp_geometry_pkg::ghist_w-2:0], ex_i.taken};
            bim_q[up_bim_idx] <= bp_geometry_pkg::ctr_next(bim_q[up_bim_idx], ex_i.taken);
            if (up_prov != bp_geometry_pkg::prov_bim)
                tctr_q[up_tbl][up[up_tbl].idx] <=
                    bp_geometry_pkg::ctr_next(tctr_q[up_tbl][up[up_tbl].idx], ex_i.taken);
            // claim an entry one history length up
            if (ex_i.mispredict && up_prov != bp_geometry_pkg::prov_t1) begin
                tag_q[alloc_tbl][up[alloc_tbl].idx]  <= up[alloc_tbl].tag;
                tctr_q[alloc_tbl][up[alloc_tbl].idx] <= ex_i.taken ?
                    bp_geometry_pkg::ctr_weak_t : bp_geometry_pkg::ctr_weak_nt;
            end
        end
    end

    // only resolved conditional branches move the history
    a_hist_stable: assert property (@(posedge clk) disable iff (rst)
        !upd |=> $stable(ghist_q));

endmodule

`default_nettype wire
